// File: common/arcade_pkg.sv
/*
 * Shared definitions for the input and option front end
 *   Scan codes of the tracked keys and key count
 *   Status word union with raw and option views
 *   Player and joystick word layouts, core reset hold length
 */

package arcade_pkg;

  ////////////////////////////////////////
  // Keyboard scan codes
  ////////////////////////////////////////

  // Player 1 keys
  localparam logic [7:0] KEY_UP    = 8'h75;
  localparam logic [7:0] KEY_DOWN  = 8'h72;
  localparam logic [7:0] KEY_LEFT  = 8'h6b;
  localparam logic [7:0] KEY_RIGHT = 8'h74;
  localparam logic [7:0] KEY_CTRL  = 8'h14;
  localparam logic [7:0] KEY_ALT   = 8'h11;
  localparam logic [7:0] KEY_SPACE = 8'h29;
  localparam logic [7:0] KEY_1     = 8'h16;
  localparam logic [7:0] KEY_5     = 8'h2e;
  localparam logic [7:0] KEY_9     = 8'h46;
  // Player 2 keys
  localparam logic [7:0] KEY_R     = 8'h2d;
  localparam logic [7:0] KEY_F     = 8'h2b;
  localparam logic [7:0] KEY_D     = 8'h23;
  localparam logic [7:0] KEY_G     = 8'h34;
  localparam logic [7:0] KEY_A     = 8'h1c;
  localparam logic [7:0] KEY_S     = 8'h1b;
  localparam logic [7:0] KEY_Q     = 8'h15;
  localparam logic [7:0] KEY_2     = 8'h1e;
  localparam logic [7:0] KEY_6     = 8'h36;
  localparam logic [7:0] KEY_0     = 8'h45;
  // Shared pause key
  localparam logic [7:0] KEY_P     = 8'h4d;

  localparam int NUM_KEYS = 21;

  ////////////////////////////////////////
  // Reset hold
  ////////////////////////////////////////

  // Cycles of core reset after the last source drops
  localparam int RESET_HOLD   = 3;
  localparam int RESET_HOLD_W = $clog2(RESET_HOLD + 1);

  ////////////////////////////////////////
  // Word layouts
  ////////////////////////////////////////

  // Host status word, read as raw bits or as option fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [3:0]  offset_y;
      logic [3:0]  offset_x;
      logic [15:0] spare;
      logic        debug;
      logic [2:0]  fx;
      logic        flip;
      logic        rotate;
      logic        full_screen;
      logic        core_reset_req;
    } opt;
  } status_word_u;

  // Player control word as seen by the core
  typedef struct packed {
    logic service;
    logic coin;
    logic start;
    logic button_3;
    logic button_2;
    logic button_1;
    logic right;
    logic left;
    logic down;
    logic up;
  } player_word_t;

  // Host joystick word, right in bit 0
  typedef struct packed {
    logic service;
    logic pause;
    logic coin;
    logic start;
    logic button_3;
    logic button_2;
    logic button_1;
    logic up;
    logic down;
    logic left;
    logic right;
  } joy_word_t;

endpackage

// File: common/key_state_if.sv
/*
 * Key state bundle between the key tracker and the input merger
 *   Player key words, pause key and a valid flag
 */

`timescale 1ns/1ps

interface key_state_if
  import arcade_pkg::*;
();

  // Key words in player layout
  player_word_t p1_keys;
  player_word_t p2_keys;
  // P key, shared by both players
  logic         pause_key;
  // Low until the key array has been cleared
  logic         key_valid;

  modport tracker (
    output p1_keys, p2_keys, pause_key, key_valid
  );

  modport merge (
    input p1_keys, p2_keys, pause_key, key_valid
  );

endinterface

// File: run_sim.sh
#!/bin/sh
# Build and run the input front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_input_frontend \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sim.f
common/arcade_pkg.sv
common/key_state_if.sv
verilog/frontend_ctrl.sv
verilog/ps2_key_tracker.sv
verilog/player_input_merge.sv
verilog/video_option_decode.sv
verilog/input_frontend_top.sv
verification/frontend_checker.sv
verification/tb_input_frontend.sv

// File: verification/frontend_checker.sv
/*
 * Output checker for the input front end
 *   Compares DUT outputs with reference values on each falling edge
 *   Counts mismatches and reports each one
 */

`timescale 1ns/1ps

module frontend_checker
  import arcade_pkg::*;
(
  input  logic         clk_sys,
  input  logic         check_en,
  input  logic         ack_idle,
  // DUT outputs
  input  logic         key_ack,
  input  player_word_t player_1,
  input  player_word_t player_2,
  input  logic         pause,
  input  logic         core_reset,
  input  logic [7:0]   video_arx,
  input  logic [7:0]   video_ary,
  input  logic [1:0]   scanline,
  input  logic         rotate,
  input  logic         flip,
  input  logic [3:0]   offset_x,
  input  logic [3:0]   offset_y,
  input  logic         debug,
  // Reference values
  input  player_word_t exp_player_1,
  input  player_word_t exp_player_2,
  input  logic         exp_pause,
  input  logic         exp_core_reset,
  // {arx, ary, scanline, rotate, flip, offset_x, offset_y, debug}
  input  logic [28:0]  exp_video,
  output int           error_count
);

  int errors = 0;

  assign error_count = errors;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[ERROR] time %0t: %s expected %0h, actual %0h",
               $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Compare at mid cycle
  ////////////////////////////////////////

  // Outputs settle after the rising edge, so the falling edge is safe
  always @(negedge clk_sys) begin
    if (check_en) begin
      // Ack must stay low whenever no event is in flight
      if (ack_idle) compare("key_ack", 32'(1'b0), 32'(key_ack));
      compare("player_1", 32'(exp_player_1), 32'(player_1));
      compare("player_2", 32'(exp_player_2), 32'(player_2));
      compare("pause", 32'(exp_pause), 32'(pause));
      compare("core_reset", 32'(exp_core_reset), 32'(core_reset));
      // Video options
      compare("video_arx", 32'(exp_video[28:21]), 32'(video_arx));
      compare("video_ary", 32'(exp_video[20:13]), 32'(video_ary));
      compare("scanline", 32'(exp_video[12:11]), 32'(scanline));
      compare("rotate", 32'(exp_video[10]), 32'(rotate));
      compare("flip", 32'(exp_video[9]), 32'(flip));
      compare("offset_x", 32'(exp_video[8:5]), 32'(offset_x));
      compare("offset_y", 32'(exp_video[4:1]), 32'(offset_y));
      compare("debug", 32'(exp_video[0]), 32'(debug));
    end
  end

endmodule

// File: verification/tb_input_frontend.sv
/*
 * Testbench for the input and option front end
 *   Clock, reset, LFSR stimulus and host key handshake driver
 *   Key state model, reference functions and core reset model
 *   Watchdog and final result
 */

`timescale 1ns/1ps

module tb_input_frontend
  import arcade_pkg::*;
();

  localparam int NUM_RANDOM   = 200;
  localparam int NUM_UNMAPPED = 16;
  // Random and unmapped events, four in the joystick test and three before the pulses
  localparam int NUM_EVENTS   = NUM_RANDOM + NUM_UNMAPPED + 7;
  localparam int WATCHDOG     = NUM_EVENTS * 20 + 1000;
  localparam int ACK_LIMIT    = 16;

  logic         clk_sys;
  logic         reset;
  logic         key_req;
  logic         key_ack;
  logic [7:0]   key_code;
  logic         key_pressed;
  joy_word_t    joystick_0;
  joy_word_t    joystick_1;
  logic         user_button;
  logic [31:0]  status;
  player_word_t player_1;
  player_word_t player_2;
  logic         pause;
  logic         core_reset;
  logic [7:0]   video_arx;
  logic [7:0]   video_ary;
  logic [1:0]   scanline;
  logic         rotate;
  logic         flip;
  logic [3:0]   offset_x;
  logic [3:0]   offset_y;
  logic         debug;

  // Reference side
  player_word_t exp_player_1;
  player_word_t exp_player_2;
  logic         exp_pause;
  logic         exp_core_reset = 1'b1;
  logic [28:0]  exp_video;
  joy_word_t    joy0_q;
  joy_word_t    joy1_q;
  logic [31:0]  status_q;
  int           low_cnt = 0;
  logic         check_en;
  logic         ack_idle;
  int           value_errors;
  int           handshake_errors;
  logic [31:0]  lfsr;
  // Key model indexed by scan code
  // Entries of unmapped codes are never read
  logic         pressed [256];
  logic [7:0]   key_list [NUM_KEYS];
  logic [31:0]  r;
  logic [7:0]   code;
  logic         press;

  always #2 clk_sys = ~clk_sys;

  input_frontend_top u_input_frontend_top (
    .clk_sys(clk_sys), .reset(reset), .key_req(key_req), .key_ack(key_ack),
    .key_code(key_code), .key_pressed(key_pressed), .joystick_0(joystick_0),
    .joystick_1(joystick_1), .user_button(user_button), .status(status),
    .player_1(player_1), .player_2(player_2), .pause(pause), .core_reset(core_reset),
    .video_arx(video_arx), .video_ary(video_ary), .scanline(scanline), .rotate(rotate),
    .flip(flip), .offset_x(offset_x), .offset_y(offset_y), .debug(debug)
  );

  frontend_checker u_frontend_checker (
    .clk_sys(clk_sys), .check_en(check_en), .ack_idle(ack_idle), .key_ack(key_ack),
    .player_1(player_1), .player_2(player_2), .pause(pause), .core_reset(core_reset),
    .video_arx(video_arx), .video_ary(video_ary), .scanline(scanline), .rotate(rotate),
    .flip(flip), .offset_x(offset_x), .offset_y(offset_y), .debug(debug),
    .exp_player_1(exp_player_1), .exp_player_2(exp_player_2), .exp_pause(exp_pause),
    .exp_core_reset(exp_core_reset), .exp_video(exp_video), .error_count(value_errors)
  );

  ////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    else return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  // Player 1 on arrows, ctrl/alt/space, 1/5/9; player 2 on R/F/D/G, A/S/Q, 2/6/0
  function automatic player_word_t key_to_player(input logic second, input joy_word_t j);
    player_word_t w;
    w.up       = pressed[second ? KEY_R : KEY_UP]     | j.up;
    w.down     = pressed[second ? KEY_F : KEY_DOWN]   | j.down;
    w.left     = pressed[second ? KEY_D : KEY_LEFT]   | j.left;
    w.right    = pressed[second ? KEY_G : KEY_RIGHT]  | j.right;
    w.button_1 = pressed[second ? KEY_A : KEY_CTRL]   | j.button_1;
    w.button_2 = pressed[second ? KEY_S : KEY_ALT]    | j.button_2;
    w.button_3 = pressed[second ? KEY_Q : KEY_SPACE]  | j.button_3;
    w.start    = pressed[second ? KEY_2 : KEY_1]      | j.start;
    w.coin     = pressed[second ? KEY_6 : KEY_5]      | j.coin;
    w.service  = pressed[second ? KEY_0 : KEY_9]      | j.service;
    return w;
  endfunction

  function automatic logic pause_ref(input joy_word_t j0, input joy_word_t j1);
    return pressed[KEY_P] | j0.pause | j1.pause;
  endfunction

  function automatic logic [28:0] video_ref(input status_word_u s);
    logic [7:0] arx;
    logic [7:0] ary;
    logic [1:0] scan;
    arx = 8'd4;
    ary = 8'd3;
    if (s.opt.full_screen) begin
      arx = 8'd16;
      ary = 8'd9;
    end else if (s.opt.rotate) begin
      arx = 8'd3;
      ary = 8'd4;
    end
    // Scanline level for each effect code, none for effect 0
    case (s.opt.fx)
      3'd0, 3'd1, 3'd5: scan = 2'd0;
      3'd2, 3'd6:       scan = 2'd1;
      3'd3, 3'd7:       scan = 2'd2;
      default:          scan = 2'd3;
    endcase
    return {arx, ary, scan, s.opt.rotate, s.opt.flip, s.opt.offset_x, s.opt.offset_y,
            s.opt.debug};
  endfunction

  // Inputs seen at each edge give the outputs for the next cycle
  always @(posedge clk_sys) begin
    joy0_q = joystick_0;
    joy1_q = joystick_1;
    status_q = status;
    if (reset || status[0] || user_button) low_cnt = 0;
    else if (low_cnt <= RESET_HOLD) low_cnt = low_cnt + 1;
    #1;
    exp_player_1 = key_to_player(1'b0, joy0_q);
    exp_player_2 = key_to_player(1'b1, joy1_q);
    exp_pause = pause_ref(joy0_q, joy1_q);
    exp_video = video_ref(status_q);
    exp_core_reset = (low_cnt <= RESET_HOLD);
  end

  ////////////////////////////////////////
  // Host side drivers
  ////////////////////////////////////////

  task automatic send_key(input logic [7:0] c, input logic p);
    int n;
    @(posedge clk_sys);
    #0.5;
    ack_idle = 1'b0;
    key_code = c;
    key_pressed = p;
    key_req = 1'b1;
    n = 0;
    while (key_ack !== 1'b1 && n < ACK_LIMIT) begin
      @(posedge clk_sys);
      #0.5;
      n++;
    end
    if (key_ack !== 1'b1) begin
      handshake_errors++;
      $display("Handshake timeout at %0t: key_ack never rose for code %0h", $time, c);
    end else begin
      pressed[c] = p;
    end
    key_req = 1'b0;
    n = 0;
    while (key_ack !== 1'b0 && n < ACK_LIMIT) begin
      @(posedge clk_sys);
      #0.5;
      n++;
    end
    if (key_ack !== 1'b0) begin
      handshake_errors++;
      $display("Handshake timeout at %0t: key_ack stuck high after req dropped", $time);
    end
    ack_idle = 1'b1;
  endtask

  task automatic random_key_event();
    logic [31:0] v;
    logic [31:0] p;
    v = take_bits(5);
    p = take_bits(1);
    send_key(key_list[int'(v % NUM_KEYS)], p[0]);
  endtask

  task automatic pulse_reset_source(input logic use_button, input int len);
    @(posedge clk_sys);
    #0.5;
    if (use_button) user_button = 1'b1;
    else status[0] = 1'b1;
    repeat (len) @(posedge clk_sys);
    #0.5;
    user_button = 1'b0;
    status[0] = 1'b0;
    repeat (RESET_HOLD + 4) @(posedge clk_sys);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clk_sys = 1'b0;
    reset = 1'b1;
    key_req = 1'b0;
    key_code = 8'h00;
    key_pressed = 1'b0;
    joystick_0 = '0;
    joystick_1 = '0;
    user_button = 1'b0;
    status = 32'h0;
    check_en = 1'b0;
    ack_idle = 1'b1;
    handshake_errors = 0;
    lfsr = 32'h7f0b;
    for (int i = 0; i < 256; i++) pressed[i] = 1'b0;
    key_list = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_CTRL, KEY_ALT, KEY_SPACE,
                 KEY_1, KEY_5, KEY_9, KEY_R, KEY_F, KEY_D, KEY_G, KEY_A, KEY_S, KEY_Q,
                 KEY_2, KEY_6, KEY_0, KEY_P};
    repeat (16) @(posedge clk_sys);
    #0.5;
    reset = 1'b0;
    // Reset values and the core reset hold are checked from here on
    check_en = 1'b1;
    repeat (8) @(posedge clk_sys);

    // Random presses and releases over all tracked keys
    for (int i = 0; i < NUM_RANDOM; i++) random_key_event();
    // Unmapped codes must leave the outputs alone
    for (int i = 0; i < NUM_UNMAPPED; i++) begin
      r = take_bits(8);
      code = r[7:0];
      for (int k = 0; k < NUM_KEYS; k++) begin
        if (code == key_list[k]) code = 8'h00;
      end
      r = take_bits(1);
      press = r[0];
      send_key(code, press);
    end

    // Random joysticks on top of the key state, with a few key events
    for (int i = 0; i < 100; i++) begin
      if (i % 25 == 0) random_key_event();
      @(posedge clk_sys);
      #0.5;
      r = take_bits(11);
      joystick_0 = r[10:0];
      r = take_bits(11);
      joystick_1 = r[10:0];
    end
    @(posedge clk_sys);
    #0.5;
    joystick_0 = '0;
    joystick_1 = '0;

    // Random status words where bit 0 also drives core reset
    for (int i = 0; i < 100; i++) begin
      @(posedge clk_sys);
      #0.5;
      status = take_bits(32);
    end
    @(posedge clk_sys);
    #0.5;
    status = 32'h3a00_00f6;
    repeat (RESET_HOLD + 4) @(posedge clk_sys);

    // Core reset pulses with keys held
    send_key(KEY_UP, 1'b1);
    send_key(KEY_P, 1'b1);
    send_key(KEY_G, 1'b1);
    pulse_reset_source(1'b0, 1);
    pulse_reset_source(1'b1, 3);
    pulse_reset_source(1'b0, 5);

    repeat (4) @(posedge clk_sys);
    $display("Errors: %0d value mismatches, %0d handshake failures",
             value_errors, handshake_errors);
    if (value_errors == 0 && handshake_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of key events
  initial begin
    repeat (WATCHDOG) @(posedge clk_sys);
    $display("Watchdog expired after %0d cycles, sequence did not complete", WATCHDOG);
    $display("Errors: %0d value mismatches, %0d handshake failures",
             value_errors, handshake_errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog/frontend_ctrl.sv
/*
 * Front end control
 *   Four-phase key handshake FSM with one update strobe per event
 *   Core reset hold counter over all reset sources
 */

`timescale 1ns/1ps

module frontend_ctrl
  import arcade_pkg::*;
(
  input  logic         clk_sys,
  input  logic         reset,
  input  logic         key_req,
  output logic         key_ack,
  input  status_word_u status,
  input  logic         user_button,
  output logic         key_update,
  output logic         core_reset
);

  enum logic [1:0] {IDLE, UPDATE, ACK, WAIT_DROP} state;

  logic [RESET_HOLD_W-1:0] hold_cnt;
  logic                    reset_src;

  ////////////////////////////////////////
  // Key handshake
  ////////////////////////////////////////

  // Tracker writes the key while in UPDATE
  assign key_update = (state == UPDATE);

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state   <= IDLE;
      key_ack <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Ack from the last event drops here
          key_ack <= 1'b0;
          if (key_req && !key_ack) state <= UPDATE;
        end
        UPDATE: state <= ACK;
        ACK: begin
          // Merger output holds the event from this edge on
          key_ack <= 1'b1;
          state   <= WAIT_DROP;
        end
        WAIT_DROP: begin
          if (!key_req) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Core reset
  ////////////////////////////////////////

  assign reset_src = reset | status.opt.core_reset_req | user_button;

  // Counter reloads while any source is up, then counts the hold down
  always_ff @(posedge clk_sys) begin
    if (reset_src) begin
      hold_cnt   <= RESET_HOLD_W'(RESET_HOLD);
      core_reset <= 1'b1;
    end else begin
      if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;
      core_reset <= (hold_cnt != '0);
    end
  end

endmodule

// File: verilog/input_frontend_top.sv
/*
 * Input and option front end top level
 *   Handshake control, key tracker, input merge, video option decode
 */

`timescale 1ns/1ps

module input_frontend_top
  import arcade_pkg::*;
(
  input  logic         clk_sys,
  input  logic         reset,
  // Host keyboard handshake
  input  logic         key_req,
  output logic         key_ack,
  input  logic [7:0]   key_code,
  input  logic         key_pressed,
  // Joysticks and board button
  input  joy_word_t    joystick_0,
  input  joy_word_t    joystick_1,
  input  logic         user_button,
  // Host status word
  input  logic [31:0]  status,
  // Core controls
  output player_word_t player_1,
  output player_word_t player_2,
  output logic         pause,
  output logic         core_reset,
  // Video options
  output logic [7:0]   video_arx,
  output logic [7:0]   video_ary,
  output logic [1:0]   scanline,
  output logic         rotate,
  output logic         flip,
  output logic [3:0]   offset_x,
  output logic [3:0]   offset_y,
  output logic         debug
);

  logic key_update;

  key_state_if u_key_state_if ();

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  frontend_ctrl u_frontend_ctrl (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .key_req     (key_req),
    .key_ack     (key_ack),
    .status      (status),
    .user_button (user_button),
    .key_update  (key_update),
    .core_reset  (core_reset)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  ps2_key_tracker u_ps2_key_tracker (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .key_update  (key_update),
    .key_code    (key_code),
    .key_pressed (key_pressed),
    .keys        (u_key_state_if.tracker)
  );

  player_input_merge u_player_input_merge (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .keys       (u_key_state_if.merge),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_1   (player_1),
    .player_2   (player_2),
    .pause      (pause)
  );

  video_option_decode u_video_option_decode (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .status    (status),
    .video_arx (video_arx),
    .video_ary (video_ary),
    .scanline  (scanline),
    .rotate    (rotate),
    .flip      (flip),
    .offset_x  (offset_x),
    .offset_y  (offset_y),
    .debug     (debug)
  );

endmodule

// File: verilog/player_input_merge.sv
/*
 * Player input merge
 *   Registered OR of key words and joystick words per player
 *   Pause from the P key and both joystick pause bits
 */

`timescale 1ns/1ps

module player_input_merge
  import arcade_pkg::*;
(
  input  logic         clk_sys,
  input  logic         reset,
  key_state_if.merge   keys,
  input  joy_word_t    joystick_0,
  input  joy_word_t    joystick_1,
  output player_word_t player_1,
  output player_word_t player_2,
  output logic         pause
);

  // Joystick fields reordered into player layout, ORed with keys
  function automatic player_word_t merge_word(input player_word_t k, input joy_word_t j);
    player_word_t w;
    w.service  = k.service  | j.service;
    w.coin     = k.coin     | j.coin;
    w.start    = k.start    | j.start;
    w.button_3 = k.button_3 | j.button_3;
    w.button_2 = k.button_2 | j.button_2;
    w.button_1 = k.button_1 | j.button_1;
    w.right    = k.right    | j.right;
    w.left     = k.left     | j.left;
    w.down     = k.down     | j.down;
    w.up       = k.up       | j.up;
    return w;
  endfunction

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      player_1 <= '0;
      player_2 <= '0;
      pause    <= 1'b0;
    end else begin
      // Keys count only once the tracker array is clean
      player_1 <= merge_word(keys.key_valid ? keys.p1_keys : '0, joystick_0);
      player_2 <= merge_word(keys.key_valid ? keys.p2_keys : '0, joystick_1);
      pause    <= (keys.key_valid & keys.pause_key) | joystick_0.pause | joystick_1.pause;
    end
  end

endmodule

// File: verilog/ps2_key_tracker.sv
/*
 * Keyboard state tracker
 *   One pressed/released bit per mapped key
 *   Scan code decode and player word assembly
 */

`timescale 1ns/1ps

module ps2_key_tracker
  import arcade_pkg::*;
(
  input  logic        clk_sys,
  input  logic        reset,
  input  logic        key_update,
  input  logic [7:0]  key_code,
  input  logic        key_pressed,
  key_state_if.tracker keys
);

  // Bits 9:0 player 1, 19:10 player 2, both in player word order
  // Bit 20 is the pause key
  logic [NUM_KEYS-1:0]         key_state;
  logic [$clog2(NUM_KEYS)-1:0] key_idx;
  logic                        key_hit;
  logic                        valid_q;

  ////////////////////////////////////////
  // Scan code decode
  ////////////////////////////////////////

  always_comb begin
    key_hit = 1'b1;
    key_idx = '0;
    case (key_code)
      KEY_UP:    key_idx = 5'd0;
      KEY_DOWN:  key_idx = 5'd1;
      KEY_LEFT:  key_idx = 5'd2;
      KEY_RIGHT: key_idx = 5'd3;
      KEY_CTRL:  key_idx = 5'd4;
      KEY_ALT:   key_idx = 5'd5;
      KEY_SPACE: key_idx = 5'd6;
      KEY_1:     key_idx = 5'd7;
      KEY_5:     key_idx = 5'd8;
      KEY_9:     key_idx = 5'd9;
      KEY_R:     key_idx = 5'd10;
      KEY_F:     key_idx = 5'd11;
      KEY_D:     key_idx = 5'd12;
      KEY_G:     key_idx = 5'd13;
      KEY_A:     key_idx = 5'd14;
      KEY_S:     key_idx = 5'd15;
      KEY_Q:     key_idx = 5'd16;
      KEY_2:     key_idx = 5'd17;
      KEY_6:     key_idx = 5'd18;
      KEY_0:     key_idx = 5'd19;
      KEY_P:     key_idx = 5'd20;
      // Unknown codes leave the array alone
      default:   key_hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // State array
  ////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      key_state <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (key_update && key_hit) key_state[key_idx] <= key_pressed;
    end
  end

  // Index order already matches the player word layout
  assign keys.p1_keys   = player_word_t'(key_state[9:0]);
  assign keys.p2_keys   = player_word_t'(key_state[19:10]);
  assign keys.pause_key = key_state[20];
  assign keys.key_valid = valid_q;

endmodule

// File: verilog/video_option_decode.sv
/*
 * Video option decode
 *   Registered status word, aspect ratio and scanline effect
 *   Rotate, flip, screen offsets and debug
 */

`timescale 1ns/1ps

module video_option_decode
  import arcade_pkg::*;
(
  input  logic         clk_sys,
  input  logic         reset,
  input  status_word_u status,
  output logic [7:0]   video_arx,
  output logic [7:0]   video_ary,
  output logic [1:0]   scanline,
  output logic         rotate,
  output logic         flip,
  output logic [3:0]   offset_x,
  output logic [3:0]   offset_y,
  output logic         debug
);

  status_word_u status_q;
  logic [2:0]   fx_m1;

  // Whole word captured once, fields read below
  always_ff @(posedge clk_sys) begin
    if (reset) status_q.raw <= '0;
    else       status_q.raw <= status.raw;
  end

  ////////////////////////////////////////
  // Aspect ratio
  ////////////////////////////////////////

  // Full screen 16:9, vertical 3:4, else 4:3
  assign video_arx = status_q.opt.full_screen ? 8'd16 : status_q.opt.rotate ? 8'd3 : 8'd4;
  assign video_ary = status_q.opt.full_screen ? 8'd9  : status_q.opt.rotate ? 8'd4 : 8'd3;

  // Fx 0 is no effect, 1 and up select scanline level fx-1
  assign fx_m1    = status_q.opt.fx - 3'd1;
  assign scanline = (status_q.opt.fx != 3'd0) ? fx_m1[1:0] : 2'd0;

  // Plain fields
  assign rotate   = status_q.opt.rotate;
  assign flip     = status_q.opt.flip;
  assign offset_x = status_q.opt.offset_x;
  assign offset_y = status_q.opt.offset_y;
  assign debug    = status_q.opt.debug;

endmodule
